//--- src/alu_pkg.sv
package alu_pkg;

  parameter int data_w = 64;
  parameter int flag_w = 6;

  // COASZP, c in the top bit
  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } flags_t;

  // conditional ops come in pairs, odd member inverts
  typedef enum logic [7:0] {
    op_add     = 8'd0,
    op_sub     = 8'd1,
    op_and     = 8'd4,
    op_or      = 8'd5,
    op_xor     = 8'd6,
    op_xnor    = 8'd7,
    op_mov     = 8'd8,
    op_zxt     = 8'd10,
    op_sxt     = 8'd11,
    op_cmov64  = 8'd16,
    op_cmov64n = 8'd17,
    op_cmov32  = 8'd18,
    op_cmov32n = 8'd19,
    op_cset    = 8'd20,
    op_csetn   = 8'd21,
    op_csand   = 8'd22,
    op_csandn  = 8'd23,
    op_csor    = 8'd24,
    op_csorn   = 8'd25
  } alu_opcode_e;

  typedef enum logic [3:0] {
    cond_z, cond_nz, cond_s, cond_ns,
    cond_ugt, cond_ule, cond_uge, cond_ult,
    cond_sgt, cond_sle, cond_sge, cond_slt,
    cond_o, cond_no, cond_p, cond_np
  } cond_e;

  typedef struct packed {
    logic        keep_flags;
    logic        no_ret;
    logic [2:0]  variant;   // width or extension source
    alu_opcode_e opcode;
  } alu_arith_t;

  typedef struct packed {
    logic       keep_flags;
    logic       no_ret;
    logic [2:0] cond_hi;
    logic [6:0] opcode_hi;
    logic       invert;     // shared with opcode bit 0
  } alu_cond_t;

  typedef union packed {
    alu_arith_t arith;
    alu_cond_t  cnd;
  } alu_op_u;

  typedef struct packed {
    logic              valid;
    logic              thread;
    alu_op_u           op;
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    flags_t            flags_in;
  } issue_t;

  typedef struct packed {
    logic              valid;
    logic              sets_flags;
    flags_t            flags;
    logic [data_w-1:0] result;
  } ret_t;

  // one-hot unit select
  typedef struct packed {
    logic add;
    logic logic_op;
    logic move;
    logic extend;
    logic cmov;
    logic cset;
  } unit_sel_t;

endpackage

//--- src/alu_decode.sv
module alu_decode (
  input  alu_pkg::alu_op_u   op,
  output alu_pkg::unit_sel_t sel,
  output logic               is_sub,
  output logic               is32,
  output logic [1:0]         ext_src,
  output alu_pkg::cond_e     cond,
  output logic               invert
);
  import alu_pkg::*;

  logic w32;

  assign w32 = op.arith.variant[0];

  // base member of the condition pair; the data path applies invert
  assign cond   = cond_e'({op.cnd.cond_hi, 1'b0});
  assign invert = op.cnd.invert;

  always_comb begin
    sel     = '0;
    is_sub  = 1'b0;
    is32    = 1'b0;
    ext_src = 2'd0;
    case (op.arith.opcode)
      op_add: begin
        sel.add = 1'b1;
        is32    = w32;
      end
      op_sub: begin
        sel.add = 1'b1;
        is_sub  = 1'b1;
        is32    = w32;
      end
      op_and, op_or, op_xor, op_xnor: begin
        sel.logic_op = 1'b1;
        is32         = w32;
      end
      op_mov: begin
        sel.move = 1'b1;
        is32     = w32;
      end
      op_zxt, op_sxt: begin
        sel.extend = 1'b1;
        ext_src    = op.arith.variant[1:0]; // 8/16/32 bit source
      end
      op_cmov64, op_cmov64n: begin
        sel.cmov = 1'b1;
      end
      op_cmov32, op_cmov32n: begin
        sel.cmov = 1'b1;
        is32     = 1'b1;
      end
      op_cset, op_csetn, op_csand, op_csandn, op_csor, op_csorn: begin
        sel.cset = 1'b1;
      end
      default: begin
        sel = '0; // unknown op, result stays zero
      end
    endcase
  end

endmodule

//--- src/alu_adder.sv
module alu_adder (
  input  logic [alu_pkg::data_w-1:0] a,
  input  logic [alu_pkg::data_w-1:0] b,
  input  logic                       is_sub,
  output logic [alu_pkg::data_w-1:0] sum,
  output logic                       c3,
  output logic                       c31,
  output logic                       c63
);
  import alu_pkg::*;

  logic [data_w-1:0] b_eff;
  logic [4:0]        lo_nib;
  logic [28:0]       mid;
  logic [32:0]       hi;

  // a - b as a + ~b + 1
  assign b_eff = is_sub ? ~b : b;

  // split at the carry taps
  assign lo_nib = {1'b0, a[3:0]} + {1'b0, b_eff[3:0]} + {4'b0, is_sub};
  assign mid    = {1'b0, a[31:4]} + {1'b0, b_eff[31:4]} + {28'b0, lo_nib[4]};
  assign hi     = {1'b0, a[63:32]} + {1'b0, b_eff[63:32]} + {32'b0, mid[28]};

  assign sum = {hi[31:0], mid[27:0], lo_nib[3:0]};

  assign c3  = lo_nib[4]; // aux carry
  assign c31 = mid[28];
  assign c63 = hi[32];

endmodule

//--- src/cond_eval.sv
module cond_eval (
  input  alu_pkg::flags_t flags,
  input  alu_pkg::cond_e  cond,
  output logic            take
);
  import alu_pkg::*;

  logic lt; // signed less than

  assign lt = flags.s ^ flags.o;

  always_comb begin
    take = 1'b0;
    case (cond)
      cond_z:   take = flags.z;
      cond_nz:  take = ~flags.z;
      cond_s:   take = flags.s;
      cond_ns:  take = ~flags.s;
      cond_ugt: take = ~(flags.c | flags.z);
      cond_ule: take = flags.c | flags.z;
      cond_uge: take = ~flags.c;
      cond_ult: take = flags.c;
      cond_sgt: take = ~(lt | flags.z);
      cond_sle: take = lt | flags.z;
      cond_sge: take = ~lt;
      cond_slt: take = lt;
      cond_o:   take = flags.o;
      cond_no:  take = ~flags.o;
      cond_p:   take = flags.p;
      cond_np:  take = ~flags.p;
      default:  take = 1'b0;
    endcase
  end

endmodule

//--- src/alu_data_path.sv
module alu_data_path (
  input  logic [alu_pkg::data_w-1:0] a,
  input  logic [alu_pkg::data_w-1:0] b,
  input  logic [alu_pkg::data_w-1:0] sum,
  input  alu_pkg::unit_sel_t         sel,
  input  logic                       is32,
  input  logic                       take,
  input  logic                       invert,
  input  alu_pkg::alu_opcode_e       op_code,
  input  logic [1:0]                 ext_src,
  output logic [alu_pkg::data_w-1:0] result
);
  import alu_pkg::*;

  logic              hit;
  logic              sxt;
  logic              cs_bit;
  logic [data_w-1:0] logic_res;
  logic [data_w-1:0] ext_res;
  logic [data_w-1:0] cmov_res;
  logic [data_w-1:0] wide;

  // odd member of a pair flips the condition
  assign hit = take ^ invert;
  assign sxt = (op_code == op_sxt);

  always_comb begin
    case (op_code)
      op_and:  logic_res = a & b;
      op_or:   logic_res = a | b;
      op_xor:  logic_res = a ^ b;
      default: logic_res = ~(a ^ b); // xnor
    endcase
  end

  // source is b, fill bit is zero unless sign extending
  always_comb begin
    case (ext_src)
      2'd0:    ext_res = {{56{sxt & b[7]}}, b[7:0]};
      2'd1:    ext_res = {{48{sxt & b[15]}}, b[15:0]};
      default: ext_res = {{32{sxt & b[31]}}, b[31:0]};
    endcase
  end

  assign cmov_res = hit ? b : a;

  always_comb begin
    case (op_code)
      op_csand, op_csandn: cs_bit = hit & a[0];
      op_csor, op_csorn:   cs_bit = hit | a[0];
      default:             cs_bit = hit;
    endcase
  end

  always_comb begin
    wide = '0;
    if (sel.add) begin
      wide = sum;
    end else if (sel.logic_op) begin
      wide = logic_res;
    end else if (sel.move) begin
      wide = b;
    end else if (sel.extend) begin
      wide = ext_res;
    end else if (sel.cmov) begin
      wide = cmov_res;
    end else if (sel.cset) begin
      wide = {{(data_w-1){1'b0}}, cs_bit};
    end
  end

  // 32-bit forms clear the upper half
  assign result = is32 ? {32'b0, wide[31:0]} : wide;

endmodule

//--- src/flag_gen.sv
module flag_gen (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [alu_pkg::data_w-1:0] result,
  input  logic [1:0]                 a_sign,  // {bit 63, bit 31}
  input  logic [1:0]                 b_sign,
  input  logic                       c3,
  input  logic                       c31,
  input  logic                       c63,
  input  logic                       is_sub,
  input  logic                       is32,
  input  alu_pkg::unit_sel_t         sel,
  output logic [alu_pkg::data_w-1:0] res_q,
  output alu_pkg::flags_t            flags
);
  import alu_pkg::*;

  unit_sel_t   sel_q;
  logic [1:0]  a_sign_q;
  logic [1:0]  b_sign_q;
  logic        c3_q;
  logic        c31_q;
  logic        c63_q;
  logic        is_sub_q;
  logic        is32_q;

  logic              top;
  logic              sa;
  logic              sb;
  logic              carry;
  logic              zero;
  logic              par;
  logic              ovf;
  logic [flag_w-1:0] coaszp;

  always_ff @(posedge clk) begin
    if (rst) begin
      sel_q <= '0;
    end else begin
      sel_q <= sel;
    end
  end

  always_ff @(posedge clk) begin
    res_q    <= result;
    a_sign_q <= a_sign;
    b_sign_q <= b_sign;
    c3_q     <= c3;
    c31_q    <= c31;
    c63_q    <= c63;
    is_sub_q <= is_sub;
    is32_q   <= is32;
  end

  assign top   = is32_q ? res_q[31] : res_q[63];
  assign sa    = is32_q ? a_sign_q[0] : a_sign_q[1];
  assign sb    = (is32_q ? b_sign_q[0] : b_sign_q[1]) ^ is_sub_q; // sign of ~b on sub
  assign carry = is32_q ? c31_q : c63_q;
  assign zero  = is32_q ? (res_q[31:0] == 32'b0) : (res_q == '0);
  assign par   = ~^res_q[7:0];
  assign ovf   = (sa == sb) && (top != sa);

  always_comb begin
    coaszp = '0;
    if (sel_q.add) begin
      // borrow is the inverted carry
      coaszp = {carry ^ is_sub_q, ovf, c3_q ^ is_sub_q, top, zero, par};
    end else if (sel_q.logic_op) begin
      coaszp = {3'b000, top, zero, par};
    end
  end

  assign flags = flags_t'(coaszp);

endmodule

//--- src/alu_top.sv
module alu_top #(
  parameter int num_threads = 2
) (
  input  logic            clk,
  input  logic            rst,
  input  alu_pkg::issue_t issue,
  input  logic            except,
  input  logic            except_thread,
  output alu_pkg::ret_t   ret
);
  import alu_pkg::*;

  // single thread core flushes on any exception
  localparam bit any_thread = (num_threads == 1);

  unit_sel_t         sel;
  cond_e             cond;
  flags_t            flags;
  logic              is_sub, is32, invert, take;
  logic [1:0]        ext_src;
  logic [data_w-1:0] sum, result, res_q;
  logic              c3, c31, c63;
  logic              except_q, except_thread_q;
  logic              kill, kill_q;
  logic              valid_q, no_ret_q, keep_flags_q;

  alu_decode u_alu_decode (
    .op(issue.op), .sel(sel), .is_sub(is_sub), .is32(is32),
    .ext_src(ext_src), .cond(cond), .invert(invert)
  );

  cond_eval u_cond_eval (.flags(issue.flags_in), .cond(cond), .take(take));

  alu_adder u_alu_adder (
    .a(issue.a), .b(issue.b), .is_sub(is_sub),
    .sum(sum), .c3(c3), .c31(c31), .c63(c63)
  );

  alu_data_path u_alu_data_path (
    .a(issue.a), .b(issue.b), .sum(sum), .sel(sel), .is32(is32), .take(take),
    .invert(invert), .op_code(issue.op.arith.opcode), .ext_src(ext_src), .result(result)
  );

  flag_gen u_flag_gen (
    .clk(clk), .rst(rst), .result(result),
    .a_sign({issue.a[63], issue.a[31]}), .b_sign({issue.b[63], issue.b[31]}),
    .c3(c3), .c31(c31), .c63(c63), .is_sub(is_sub), .is32(is32),
    .sel(sel), .res_q(res_q), .flags(flags)
  );

  // exception this cycle or the one before
  assign kill = (except && (except_thread == issue.thread || any_thread)) ||
                (except_q && (except_thread_q == issue.thread || any_thread));

  always_ff @(posedge clk) begin
    if (rst) begin
      except_q        <= 1'b0;
      except_thread_q <= 1'b0;
      kill_q          <= 1'b0;
      valid_q         <= 1'b0;
      no_ret_q        <= 1'b0;
      keep_flags_q    <= 1'b0;
    end else begin
      except_q        <= except;
      except_thread_q <= except_thread;
      kill_q          <= kill;
      valid_q         <= issue.valid;
      no_ret_q        <= issue.op.arith.no_ret;
      keep_flags_q    <= issue.op.arith.keep_flags;
    end
  end

  assign ret = '{valid: valid_q & ~no_ret_q & ~kill_q, sets_flags: ~keep_flags_q,
                 flags: flags, result: res_q};

endmodule

//--- bench/alu_checker.sv
module alu_checker (
  input  logic            clk,
  input  logic            rst,
  input  alu_pkg::issue_t issue,
  input  logic            except,
  input  logic            except_thread,
  input  alu_pkg::ret_t   ret,
  output int              n_tests,
  output int              n_errors
);
  timeunit 1ns;
  timeprecision 100ps;
  import alu_pkg::*;

  ret_t        exp_q;
  alu_opcode_e op_q;
  logic        pend = 1'b0;
  logic        exc_q = 1'b0;
  logic        exc_thr_q = 1'b0;

  // odd code negates the even base condition
  function automatic logic cond_true(logic [3:0] code, flags_t f);
    logic t;
    case (code[3:1])
      3'd0: t = f.z;
      3'd1: t = f.s;
      3'd2: t = !f.c && !f.z;   // ugt
      3'd3: t = !f.c;
      3'd4: t = !f.z && (f.s == f.o);
      3'd5: t = f.s == f.o;
      3'd6: t = f.o;
      default: t = f.p;
    endcase
    return t ^ code[0];
  endfunction

  function automatic ret_t model(issue_t is, logic kill);
    ret_t        r;
    alu_opcode_e op;
    logic [2:0]  v;
    logic [64:0] full;
    logic        w32, hit, sa, sb, sr, szp, bit0;
    logic [63:0] a, b, res, mask, emask;
    int          ext_w;
    op = is.op.arith.opcode;
    v = is.op.arith.variant;
    a = is.a;
    b = is.b;
    w32 = (v[0] && (op inside {op_add, op_sub, op_and, op_or, op_xor, op_xnor, op_mov})) ||
          (op inside {op_cmov32, op_cmov32n});
    mask = w32 ? 64'h0000_0000_ffff_ffff : '1;
    sa = w32 ? a[31] : a[63];
    sb = w32 ? b[31] : b[63];
    hit = cond_true({is.op.cnd.cond_hi, is.op.cnd.invert}, is.flags_in);
    r = '0;
    res = '0;
    szp = 1'b0;
    case (op)
      op_add: begin
        full = {1'b0, a & mask} + {1'b0, b & mask};
        res = a + b;
        sr = w32 ? res[31] : res[63];
        r.flags.c = w32 ? full[32] : full[64];
        r.flags.a = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
        r.flags.o = (sa == sb) && (sr != sa);
        szp = 1'b1;
      end
      op_sub: begin
        res = a - b;
        sr = w32 ? res[31] : res[63];
        r.flags.c = (a & mask) < (b & mask); // borrow
        r.flags.a = a[3:0] < b[3:0];
        r.flags.o = (sa != sb) && (sr != sa);
        szp = 1'b1;
      end
      op_and: begin
        res = a & b;
        szp = 1'b1;
      end
      op_or: begin
        res = a | b;
        szp = 1'b1;
      end
      op_xor: begin
        res = a ^ b;
        szp = 1'b1;
      end
      op_xnor: begin
        res = ~(a ^ b);
        szp = 1'b1;
      end
      op_mov: res = b;
      op_zxt, op_sxt: begin
        ext_w = (v == 3'd0) ? 8 : (v == 3'd1) ? 16 : 32;
        emask = (64'd1 << ext_w) - 64'd1;
        res = b & emask;
        if (op == op_sxt && b[ext_w-1]) begin
          res = res | ~emask;
        end
      end
      op_cmov64, op_cmov64n, op_cmov32, op_cmov32n: res = hit ? b : a;
      default: begin
        bit0 = hit;
        if (op inside {op_csand, op_csandn}) begin
          bit0 = hit & a[0];
        end else if (op inside {op_csor, op_csorn}) begin
          bit0 = hit | a[0];
        end
        res = {63'b0, bit0};
      end
    endcase
    res = res & mask;
    if (szp) begin
      r.flags.s = w32 ? res[31] : res[63];
      r.flags.z = res == 64'd0;
      r.flags.p = ~^res[7:0];
    end
    r.result = res;
    r.valid = is.valid && !is.op.arith.no_ret && !kill;
    r.sets_flags = !is.op.arith.keep_flags;
    return r;
  endfunction

  task automatic check_ret();
    string msg;
    msg = "";
    if (ret.valid !== exp_q.valid) begin
      msg = $sformatf(" valid %0b, expected %0b", ret.valid, exp_q.valid);
    end else if (exp_q.valid && ret.sets_flags !== exp_q.sets_flags) begin
      msg = $sformatf(" sets_flags %0b, expected %0b", ret.sets_flags, exp_q.sets_flags);
    end else if (exp_q.valid && ret.flags !== exp_q.flags) begin
      msg = $sformatf(" flags %b, expected %b", ret.flags, exp_q.flags);
    end else if (exp_q.valid && ret.result !== exp_q.result) begin
      msg = $sformatf(" result %h, expected %h", ret.result, exp_q.result);
    end
    n_tests++;
    if (msg == "") begin
      $display("[ ok ] %0t test %0d %s", $time, n_tests, op_q.name());
    end else begin
      n_errors++;
      $display("[FAIL] %0t test %0d %s:%s", $time, n_tests, op_q.name(), msg);
    end
  endtask

  initial begin
    n_tests = 0;
    n_errors = 0;
  end

  // ret and the next issue are both stable here
  always @(negedge clk) begin
    if (pend) begin
      check_ret();
    end else if (!rst && ret.valid !== 1'b0) begin
      n_errors++;
      $display("[FAIL] %0t ret.valid is %b with no operation issued", $time, ret.valid);
    end
    pend = !rst && issue.valid;
    op_q = issue.op.arith.opcode;
    exp_q = model(issue, (except && except_thread == issue.thread) ||
                         (exc_q && exc_thr_q == issue.thread));
    exc_q = !rst && except;
    exc_thr_q = except_thread;
  end

endmodule

//--- bench/alu_tb.sv
module alu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import alu_pkg::*;

  typedef struct packed {
    alu_opcode_e opcode;
    logic [2:0]  variant;
    logic        keep_flags;
    logic        no_ret;
    flags_t      flags_in;
    logic        except;
    logic        except_thread;
    logic        thread;
    logic [2:0]  a_kind;  // 0 random, else an edge value
    logic [2:0]  b_kind;
  } row_t;

  logic        clk;
  logic        rst;
  issue_t      issue;
  logic        except;
  logic        except_thread;
  ret_t        ret;
  row_t        rows[$];
  int          n_rows = 0;
  int          n_tests;
  int          n_errors;
  logic [31:0] lfsr;

  alu_top #(.num_threads(2)) u_alu_top (
    .clk(clk), .rst(rst), .issue(issue), .except(except),
    .except_thread(except_thread), .ret(ret)
  );

  alu_checker u_alu_checker (
    .clk(clk), .rst(rst), .issue(issue), .except(except), .except_thread(except_thread),
    .ret(ret), .n_tests(n_tests), .n_errors(n_errors)
  );

  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) begin
      lfsr = lfsr ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[62:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic logic [63:0] operand(logic [2:0] kind);
    case (kind)
      3'd1: return 64'h0;
      3'd2: return '1;
      3'd3: return 64'h7fff_ffff_ffff_ffff;
      3'd4: return 64'h8000_0000_0000_0000;
      3'd5: return 64'h0000_0000_7fff_ffff;
      3'd6: return 64'h0000_0000_8000_0000;
      3'd7: return 64'h1;
      default: return rand_bits(64);
    endcase
  endfunction

  function automatic row_t mk(alu_opcode_e op, logic [2:0] variant, logic [2:0] ak,
                              logic [2:0] bk);
    row_t r;
    r = '0;
    r.opcode = op;
    r.variant = variant;
    r.a_kind = ak;
    r.b_kind = bk;
    return r;
  endfunction

  task automatic build_table();
    alu_opcode_e logic_ops[5] = '{op_and, op_or, op_xor, op_xnor, op_mov};
    alu_opcode_e cond_ops[10] = '{op_cmov64, op_cmov64n, op_cmov32, op_cmov32n, op_cset,
                                  op_csetn, op_csand, op_csandn, op_csor, op_csorn};
    logic [2:0]  ak[10] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd6, 3'd1, 3'd4};
    logic [2:0]  bk[10] = '{3'd0, 3'd0, 3'd1, 3'd7, 3'd7, 3'd2, 3'd7, 3'd6, 3'd7, 3'd7};
    logic [2:0]  ext_b[4] = '{3'd0, 3'd0, 3'd2, 3'd6};
    // {thread, except, except_thread, keep_flags, no_ret}
    logic [4:0]  ctl[12] = '{5'b00010, 5'b00001, 5'b10011, 5'b01000, 5'b00000, 5'b00000,
                             5'b11000, 5'b00000, 5'b11100, 5'b00000, 5'b10000, 5'b10000};
    logic [63:0] fl;
    row_t        r;
    foreach (ak[i]) begin
      for (int k = 0; k < 4; k++) begin
        rows.push_back(mk(k[0] ? op_sub : op_add, {2'b0, k[1]}, ak[i], bk[i]));
      end
    end
    foreach (logic_ops[i]) begin
      for (int k = 0; k < 4; k++) begin
        rows.push_back(mk(logic_ops[i], {2'b0, k[0]}, k[1] ? 3'd2 : 3'd0, k[1] ? 3'd2 : 3'd0));
      end
    end
    for (int v = 0; v < 3; v++) begin
      foreach (ext_b[k]) begin
        rows.push_back(mk(op_zxt, v[2:0], 3'd0, ext_b[k]));
        rows.push_back(mk(op_sxt, v[2:0], 3'd0, ext_b[k]));
      end
    end
    for (int v = 0; v < 8; v++) begin
      foreach (cond_ops[j]) begin
        if (!j[0]) begin
          fl = rand_bits(6); // inverted partner reuses the flags
        end
        r = mk(cond_ops[j], v[2:0], 3'd0, 3'd0);
        r.flags_in = fl[5:0];
        rows.push_back(r);
      end
    end
    foreach (ctl[i]) begin
      r = mk(op_add, 3'd0, 3'd0, 3'd0);
      {r.thread, r.except, r.except_thread, r.keep_flags, r.no_ret} = ctl[i];
      rows.push_back(r);
    end
  endtask

  task automatic apply_row(row_t r);
    issue.valid = 1'b1;
    issue.thread = r.thread;
    issue.op.arith.keep_flags = r.keep_flags;
    issue.op.arith.no_ret = r.no_ret;
    issue.op.arith.variant = r.variant;
    issue.op.arith.opcode = r.opcode;
    issue.a = operand(r.a_kind);
    issue.b = operand(r.b_kind);
    issue.flags_in = r.flags_in;
    except = r.except;
    except_thread = r.except_thread;
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #10 clk = ~clk;
    end
  end

  initial begin
    lfsr = 32'hc65be7ff;
    rst = 1'b1;
    issue = '0;
    except = 1'b0;
    except_thread = 1'b0;
    build_table();
    n_rows = rows.size();
    repeat (2) @(posedge clk);
    #2 rst = 1'b0;
    foreach (rows[i]) begin
      apply_row(rows[i]);
      @(posedge clk);
      #2;
    end
    issue.valid = 1'b0;
    except = 1'b0;
    repeat (3) @(posedge clk);
    $display("tests %0d of %0d, errors %0d", n_tests, n_rows, n_errors);
    if (n_errors == 0 && n_tests == n_rows) begin
      $display("TEST RESULT: PASS");
    end else begin
      if (n_tests != n_rows) begin
        $display("only %0d of %0d operations were checked", n_tests, n_rows);
      end
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    wait (n_rows > 0);
    repeat (n_rows + 20) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", n_rows + 20);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

//--- src.f
src/alu_pkg.sv
src/alu_decode.sv
src/alu_adder.sv
src/cond_eval.sv
src/alu_data_path.sv
src/flag_gen.sv
src/alu_top.sv
bench/alu_checker.sv
bench/alu_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps -f src.f --top-module alu_tb \
  -o alu_sim && ./obj_dir/alu_sim | tee sim.log
grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
